//--- logic/ooo_backend_top.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_backend_top #(
  parameter int ROB_TAG_W = 3
) (
  input  logic                 clk,
  input  logic                 rst,
  input  ooo_pkg::issue_req_t  issue,
  input  ooo_pkg::wb_req_t     wb,
  input  logic [ROB_TAG_W-1:0] wb_tag,
  output logic [ROB_TAG_W-1:0] issue_tag,
  output logic                 rob_full,
  output ooo_pkg::operand_t    rs1_op,
  output logic [ROB_TAG_W-1:0] rs1_tag,
  output ooo_pkg::operand_t    rs2_op,
  output logic [ROB_TAG_W-1:0] rs2_tag,
  output ooo_pkg::commit_req_t commit,
  output logic [ROB_TAG_W-1:0] commit_tag
);

  import rv_arch_pkg::*;
  import ooo_pkg::*;

  issue_req_t           sb_issue;
  sb_read_t             sb_rs1;
  sb_read_t             sb_rs2;
  logic [ROB_TAG_W-1:0] sb_rs1_tag;
  logic [ROB_TAG_W-1:0] sb_rs2_tag;
  logic [ROB_TAG_W-1:0] lookup1_tag;
  logic [ROB_TAG_W-1:0] lookup2_tag;
  logic                 lookup1_done;
  logic                 lookup2_done;
  xlen_t                lookup1_value;
  xlen_t                lookup2_value;

  // an issue dropped by a full ROB must not mark rd pending
  assign sb_issue.valid = issue.valid && !rob_full;
  assign sb_issue.rd    = issue.rd;
  assign sb_issue.rs1   = issue.rs1;
  assign sb_issue.rs2   = issue.rs2;

  // tail pointer doubles as the tag of this cycle's issue
  reorder_buffer #(
    .ROB_TAG_W(ROB_TAG_W)
  ) reorder_buffer_inst (
    .clk          (clk),
    .rst          (rst),
    .issue_valid  (issue.valid),
    .issue_rd     (issue.rd),
    .wb           (wb),
    .wb_tag       (wb_tag),
    .alloc_tag    (issue_tag),
    .rob_full     (rob_full),
    .lookup1_tag  (lookup1_tag),
    .lookup2_tag  (lookup2_tag),
    .lookup1_done (lookup1_done),
    .lookup1_value(lookup1_value),
    .lookup2_done (lookup2_done),
    .lookup2_value(lookup2_value),
    .commit       (commit),
    .commit_tag   (commit_tag)
  );

  regfile_scoreboard #(
    .ROB_TAG_W(ROB_TAG_W)
  ) regfile_scoreboard_inst (
    .clk       (clk),
    .rst       (rst),
    .issue     (sb_issue),
    .issue_tag (issue_tag),
    .commit    (commit),
    .commit_tag(commit_tag),
    .sb_rs1    (sb_rs1),
    .sb_rs1_tag(sb_rs1_tag),
    .sb_rs2    (sb_rs2),
    .sb_rs2_tag(sb_rs2_tag)
  );

  operand_resolve #(
    .ROB_TAG_W(ROB_TAG_W)
  ) operand_resolve_inst (
    .sb_rs1       (sb_rs1),
    .sb_rs1_tag   (sb_rs1_tag),
    .sb_rs2       (sb_rs2),
    .sb_rs2_tag   (sb_rs2_tag),
    .lookup1_tag  (lookup1_tag),
    .lookup2_tag  (lookup2_tag),
    .lookup1_done (lookup1_done),
    .lookup1_value(lookup1_value),
    .lookup2_done (lookup2_done),
    .lookup2_value(lookup2_value),
    .rs1_op       (rs1_op),
    .rs1_tag      (rs1_tag),
    .rs2_op       (rs2_op),
    .rs2_tag      (rs2_tag)
  );

endmodule

`default_nettype wire

//--- logic/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

  // one instruction from the front end
  typedef struct packed {
    logic                 valid;
    rv_arch_pkg::reg_idx_t rd;
    rv_arch_pkg::reg_idx_t rs1;
    rv_arch_pkg::reg_idx_t rs2;
  } issue_req_t;

  // result from an execution unit, tag carried on its own port
  typedef struct packed {
    logic               valid;
    rv_arch_pkg::xlen_t value;
  } wb_req_t;

  // retirement of the ROB head into the register file
  typedef struct packed {
    logic                  valid;
    rv_arch_pkg::reg_idx_t rd;
    rv_arch_pkg::xlen_t    value;
  } commit_req_t;

  typedef struct packed {
    logic               ready;
    rv_arch_pkg::xlen_t value;
  } operand_t;

  // raw scoreboard answer, before any ROB forwarding
  typedef struct packed {
    logic               ready;
    rv_arch_pkg::xlen_t value;
  } sb_read_t;

endpackage

`default_nettype wire

//--- logic/operand_resolve.sv
`timescale 1ns/1ps
`default_nettype none

module operand_resolve #(
  parameter int ROB_TAG_W = 3
) (
  input  ooo_pkg::sb_read_t    sb_rs1,
  input  logic [ROB_TAG_W-1:0] sb_rs1_tag,
  input  ooo_pkg::sb_read_t    sb_rs2,
  input  logic [ROB_TAG_W-1:0] sb_rs2_tag,
  output logic [ROB_TAG_W-1:0] lookup1_tag,
  output logic [ROB_TAG_W-1:0] lookup2_tag,
  input  logic                 lookup1_done,
  input  rv_arch_pkg::xlen_t   lookup1_value,
  input  logic                 lookup2_done,
  input  rv_arch_pkg::xlen_t   lookup2_value,
  output ooo_pkg::operand_t    rs1_op,
  output logic [ROB_TAG_W-1:0] rs1_tag,
  output ooo_pkg::operand_t    rs2_op,
  output logic [ROB_TAG_W-1:0] rs2_tag
);

  import rv_arch_pkg::*;
  import ooo_pkg::*;

  // committed value first, then a finished ROB result
  function automatic operand_t resolve(sb_read_t sb, logic fwd_done, xlen_t fwd_value);
    operand_t op;
    if (sb.ready) begin
      op.ready = 1'b1;
      op.value = sb.value;
    end else if (fwd_done) begin
      op.ready = 1'b1;
      op.value = fwd_value;
    end else begin
      op.ready = 1'b0;
      op.value = sb.value;
    end
    return op;
  endfunction

  assign lookup1_tag = sb_rs1_tag;
  assign lookup2_tag = sb_rs2_tag;

  assign rs1_op  = resolve(sb_rs1, lookup1_done, lookup1_value);
  assign rs2_op  = resolve(sb_rs2, lookup2_done, lookup2_value);

  // tag is only meaningful while the operand is not ready
  assign rs1_tag = sb_rs1_tag;
  assign rs2_tag = sb_rs2_tag;

endmodule

`default_nettype wire

//--- logic/regfile_scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

module regfile_scoreboard #(
  parameter int ROB_TAG_W = 3
) (
  input  logic                     clk,
  input  logic                     rst,
  input  ooo_pkg::issue_req_t      issue,
  input  logic [ROB_TAG_W-1:0]     issue_tag,
  input  ooo_pkg::commit_req_t     commit,
  input  logic [ROB_TAG_W-1:0]     commit_tag,
  output ooo_pkg::sb_read_t        sb_rs1,
  output logic [ROB_TAG_W-1:0]     sb_rs1_tag,
  output ooo_pkg::sb_read_t        sb_rs2,
  output logic [ROB_TAG_W-1:0]     sb_rs2_tag
);

  import rv_arch_pkg::*;

  localparam int NUM_REGS = 32;

  xlen_t                regs_q    [NUM_REGS];
  logic [ROB_TAG_W-1:0] tag_q     [NUM_REGS];
  logic [NUM_REGS-1:0]  pending_q;

  logic commit_we;
  logic issue_we;

  // x0 is never written and never marked pending
  assign commit_we = commit.valid && (commit.rd != reg_idx_t'(0));
  assign issue_we  = issue.valid && (issue.rd != reg_idx_t'(0));

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
        tag_q[i]  <= '0;
      end
      pending_q <= '0;
    end else begin
      if (commit_we) begin
        regs_q[commit.rd] <= commit.value;
        // only the youngest producer may release the register
        if (pending_q[commit.rd] && (tag_q[commit.rd] == commit_tag)) begin
          pending_q[commit.rd] <= 1'b0;
        end
      end

      // a same-cycle issue to rd overrides the release above
      if (issue_we) begin
        tag_q[issue.rd]     <= issue_tag;
        pending_q[issue.rd] <= 1'b1;
      end
    end
  end

  // source reads see state from before this edge
  always_comb begin
    sb_rs1.value = regs_q[issue.rs1];
    sb_rs1.ready = ~pending_q[issue.rs1];
    sb_rs1_tag   = tag_q[issue.rs1];

    sb_rs2.value = regs_q[issue.rs2];
    sb_rs2.ready = ~pending_q[issue.rs2];
    sb_rs2_tag   = tag_q[issue.rs2];
  end

endmodule

`default_nettype wire

//--- logic/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer #(
  parameter int ROB_TAG_W = 3
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  issue_valid,
  input  rv_arch_pkg::reg_idx_t issue_rd,
  input  ooo_pkg::wb_req_t      wb,
  input  logic [ROB_TAG_W-1:0]  wb_tag,
  output logic [ROB_TAG_W-1:0]  alloc_tag,
  output logic                  rob_full,
  input  logic [ROB_TAG_W-1:0]  lookup1_tag,
  input  logic [ROB_TAG_W-1:0]  lookup2_tag,
  output logic                  lookup1_done,
  output rv_arch_pkg::xlen_t    lookup1_value,
  output logic                  lookup2_done,
  output rv_arch_pkg::xlen_t    lookup2_value,
  output ooo_pkg::commit_req_t  commit,
  output logic [ROB_TAG_W-1:0]  commit_tag
);

  import rv_arch_pkg::*;

  localparam int DEPTH = 1 << ROB_TAG_W;

  typedef logic [ROB_TAG_W-1:0] tag_t;
  // extra msb is the wrap bit
  typedef logic [ROB_TAG_W:0] ptr_t;

  ptr_t head_q;
  ptr_t tail_q;

  logic [DEPTH-1:0] valid_q;
  logic [DEPTH-1:0] done_q;
  reg_idx_t         rd_q    [DEPTH];
  xlen_t            value_q [DEPTH];

  tag_t head_idx;
  tag_t tail_idx;
  logic alloc_fire;
  logic commit_fire;
  logic wb_fire;

  assign head_idx = head_q[ROB_TAG_W-1:0];
  assign tail_idx = tail_q[ROB_TAG_W-1:0];

  // same slot, different lap
  assign rob_full = (head_q[ROB_TAG_W] != tail_q[ROB_TAG_W]) && (head_idx == tail_idx);

  assign alloc_tag   = tail_idx;
  assign alloc_fire  = issue_valid && !rob_full;
  assign commit_fire = valid_q[head_idx] && done_q[head_idx];
  // writebacks to a slot that is not in flight are dropped
  assign wb_fire     = wb.valid && valid_q[wb_tag];

  always_ff @(posedge clk) begin
    if (rst) begin
      head_q  <= '0;
      tail_q  <= '0;
      valid_q <= '0;
      done_q  <= '0;
    end else begin
      if (wb_fire) begin
        done_q[wb_tag] <= 1'b1;
      end

      if (commit_fire) begin
        valid_q[head_idx] <= 1'b0;
        done_q[head_idx]  <= 1'b0;
        head_q            <= head_q + 1'b1;
      end

      // a fresh entry starts without a result
      if (alloc_fire) begin
        valid_q[tail_idx] <= 1'b1;
        done_q[tail_idx]  <= 1'b0;
        tail_q            <= tail_q + 1'b1;
      end
    end
  end

  // entry payload
  always_ff @(posedge clk) begin
    if (wb_fire) begin
      value_q[wb_tag] <= wb.value;
    end
    if (alloc_fire) begin
      rd_q[tail_idx] <= issue_rd;
    end
  end

  // forwarding lookups for the operand resolver
  always_comb begin
    lookup1_done  = valid_q[lookup1_tag] && done_q[lookup1_tag];
    lookup1_value = value_q[lookup1_tag];
    lookup2_done  = valid_q[lookup2_tag] && done_q[lookup2_tag];
    lookup2_value = value_q[lookup2_tag];
  end

  // in-order retirement, one per cycle
  always_comb begin
    commit.valid = commit_fire;
    commit.rd    = rd_q[head_idx];
    commit.value = value_q[head_idx];
    commit_tag   = head_idx;
  end

endmodule

`default_nettype wire

//--- logic/rv_arch_pkg.sv
`default_nettype none

package rv_arch_pkg;

  localparam int XLEN = 32;
  localparam int REG_IDX_W = 5;

  // one architectural data word
  typedef logic [XLEN-1:0] xlen_t;

  // x0 to x31
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

endpackage

`default_nettype wire

//--- project.f
logic/rv_arch_pkg.sv
logic/ooo_pkg.sv
logic/regfile_scoreboard.sv
logic/reorder_buffer.sv
logic/operand_resolve.sv
logic/ooo_backend_top.sv
verif/tb_ooo_backend.sv

//--- verif/tb_ooo_backend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_backend;

  import rv_arch_pkg::*;
  import ooo_pkg::*;

  localparam int ROB_TAG_W    = 3;
  localparam int DEPTH        = 1 << ROB_TAG_W;
  localparam int RESET_CYCLES = 16;
  localparam int RUN_CYCLES   = 2000;
  localparam int DRAIN_CYCLES = 200;
  // reset, random run and drain, with generous margin
  localparam int MAX_CYCLES   = 3000;

  typedef logic [ROB_TAG_W-1:0] tag_t;

  logic        clk;
  logic        rst;
  issue_req_t  issue;
  wb_req_t     wb;
  tag_t        wb_tag;
  tag_t        issue_tag;
  logic        rob_full;
  operand_t    rs1_op;
  tag_t        rs1_tag;
  operand_t    rs2_op;
  tag_t        rs2_tag;
  commit_req_t commit;
  tag_t        commit_tag;

  // reference model state
  xlen_t            ref_regs [32];
  logic [31:0]      ref_pend;
  tag_t             ref_tag  [32];
  logic [DEPTH-1:0] ref_valid;
  logic [DEPTH-1:0] ref_done;
  reg_idx_t         ref_rd   [DEPTH];
  xlen_t            ref_val  [DEPTH];
  tag_t             ref_head;
  tag_t             ref_tail;
  int               ref_count;

  logic [31:0] lcg_state;
  int          cycle_count = 0;

  ooo_backend_top #(
    .ROB_TAG_W(ROB_TAG_W)
  ) ooo_backend_top_inst (
    .clk       (clk),
    .rst       (rst),
    .issue     (issue),
    .wb        (wb),
    .wb_tag    (wb_tag),
    .issue_tag (issue_tag),
    .rob_full  (rob_full),
    .rs1_op    (rs1_op),
    .rs1_tag   (rs1_tag),
    .rs2_op    (rs2_op),
    .rs2_tag   (rs2_tag),
    .commit    (commit),
    .commit_tag(commit_tag)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      stop_with_failure($sformatf("run did not finish within %0d cycles", MAX_CYCLES));
    end
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // half the picks land on x0..x7 to provoke hazards
  function automatic reg_idx_t pick_reg();
    logic [31:0] r;
    r = next_rand();
    if (r[31]) begin
      return r[28:24];
    end
    return {2'b00, r[26:24]};
  endfunction

  task automatic reset_model();
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
      ref_tag[i]  = '0;
    end
    for (int i = 0; i < DEPTH; i++) begin
      ref_rd[i]  = '0;
      ref_val[i] = '0;
    end
    ref_pend  = '0;
    ref_valid = '0;
    ref_done  = '0;
    ref_head  = '0;
    ref_tail  = '0;
    ref_count = 0;
  endtask

  // apply one clock edge: writeback, then commit, then issue
  task automatic step_model();
    tag_t     h;
    reg_idx_t rd;
    logic     retire;
    logic     alloc;
    h      = ref_head;
    rd     = ref_rd[h];
    retire = ref_valid[h] && ref_done[h];
    alloc  = issue.valid && (ref_count != DEPTH);
    if (wb.valid && ref_valid[wb_tag]) begin
      ref_done[wb_tag] = 1'b1;
      ref_val[wb_tag]  = wb.value;
    end
    if (retire) begin
      if (rd != reg_idx_t'(0)) begin
        ref_regs[rd] = ref_val[h];
        if (ref_pend[rd] && (ref_tag[rd] == h)) begin
          ref_pend[rd] = 1'b0;
        end
      end
      ref_valid[h] = 1'b0;
      ref_done[h]  = 1'b0;
      ref_head     = h + tag_t'(1);
    end
    if (alloc) begin
      ref_valid[ref_tail] = 1'b1;
      ref_done[ref_tail]  = 1'b0;
      ref_rd[ref_tail]    = issue.rd;
      if (issue.rd != reg_idx_t'(0)) begin
        ref_tag[issue.rd]  = ref_tail;
        ref_pend[issue.rd] = 1'b1;
      end
      ref_tail = ref_tail + tag_t'(1);
    end
    ref_count = ref_count + (alloc ? 1 : 0) - (retire ? 1 : 0);
  endtask

  task automatic drive_inputs(input bit allow_issue);
    logic [31:0] r;
    tag_t        start;
    tag_t        t;
    r           = next_rand();
    issue.valid = allow_issue && (r[31:30] != 2'b00);
    issue.rd    = pick_reg();
    issue.rs1   = pick_reg();
    issue.rs2   = pick_reg();
    wb          = '0;
    wb_tag      = '0;
    r           = next_rand();
    // writeback to a random in-flight entry without a result yet
    if (r[31] || !allow_issue) begin
      start = r[26:24];
      for (int i = 0; i < DEPTH; i++) begin
        t = start + tag_t'(i);
        if (!wb.valid && ref_valid[t] && !ref_done[t]) begin
          wb.valid = 1'b1;
          wb_tag   = t;
        end
      end
      if (wb.valid) begin
        wb.value = next_rand();
      end
    end
  endtask

  function automatic operand_t expect_operand(input reg_idx_t src);
    operand_t op;
    tag_t     t;
    t        = ref_tag[src];
    op.ready = 1'b1;
    op.value = ref_regs[src];
    if (ref_pend[src]) begin
      op.ready = ref_valid[t] && ref_done[t];
      op.value = ref_val[t];
    end
    return op;
  endfunction

  task automatic check_operand(input string what, input operand_t got, input tag_t got_tag,
                               input operand_t exp, input tag_t exp_tag);
    if (got.ready !== exp.ready) begin
      stop_with_failure($sformatf("error at %0t: %s ready %b, expected %b",
                                  $time, what, got.ready, exp.ready));
    end else if (exp.ready && (got.value !== exp.value)) begin
      stop_with_failure($sformatf("error at %0t: %s value %h, expected %h",
                                  $time, what, got.value, exp.value));
    end else if (!exp.ready && (got_tag !== exp_tag)) begin
      stop_with_failure($sformatf("error at %0t: %s tag %0d, expected %0d",
                                  $time, what, got_tag, exp_tag));
    end
  endtask

  task automatic check_commit(input commit_req_t got, input tag_t got_tag,
                              input commit_req_t exp, input tag_t exp_tag);
    if (got.valid !== exp.valid) begin
      stop_with_failure($sformatf("error at %0t: commit valid %b, expected %b",
                                  $time, got.valid, exp.valid));
    end else if (exp.valid && ((got.rd !== exp.rd) || (got.value !== exp.value) ||
                               (got_tag !== exp_tag))) begin
      stop_with_failure($sformatf("error at %0t: commit rd %0d val %h tag %0d, expected %0d %h %0d",
                                  $time, got.rd, got.value, got_tag,
                                  exp.rd, exp.value, exp_tag));
    end
  endtask

  task automatic check_tag(input tag_t got_tag, input logic got_full,
                           input tag_t exp_tag, input logic exp_full);
    if ((got_tag !== exp_tag) || (got_full !== exp_full)) begin
      stop_with_failure($sformatf("error at %0t: issue_tag %0d full %b, expected %0d %b",
                                  $time, got_tag, got_full, exp_tag, exp_full));
    end
  endtask

  task automatic check_outputs();
    commit_req_t exp_commit;
    exp_commit.valid = ref_valid[ref_head] && ref_done[ref_head];
    exp_commit.rd    = ref_rd[ref_head];
    exp_commit.value = ref_val[ref_head];
    check_tag(issue_tag, rob_full, ref_tail, ref_count == DEPTH);
    check_operand("rs1", rs1_op, rs1_tag, expect_operand(issue.rs1), ref_tag[issue.rs1]);
    check_operand("rs2", rs2_op, rs2_tag, expect_operand(issue.rs2), ref_tag[issue.rs2]);
    check_commit(commit, commit_tag, exp_commit, ref_head);
  endtask

  initial begin
    lcg_state = 32'h73f5af15;
    rst       = 1'b1;
    issue     = '0;
    wb        = '0;
    wb_tag    = '0;
    reset_model();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;

    // random traffic, then writebacks only until the ROB empties
    for (int n = 0; n < RUN_CYCLES + DRAIN_CYCLES; n++) begin
      drive_inputs(n < RUN_CYCLES);
      #2;
      check_outputs();
      @(posedge clk);
      step_model();
      #1;
    end

    if (ref_count != 0) begin
      stop_with_failure("reorder buffer still held instructions after the drain");
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

`default_nettype wire
